// File: Makefile
# Verilator build and run of the cnn_top testbench

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module tb_cnn_top -f all.f -o sim_tb

run: compile
	./obj_dir/sim_tb | tee sim.log
	@if grep -q "test failed" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

// File: all.f
cnn_pkg.sv
cnn_ifs.sv
inst_decoder.sv
ddr_fetch_control.sv
line_buffer.sv
compute_control.sv
pe_core.sv
cnn_top.sv
tb_cnn_top.sv

// File: cnn_ifs.sv
`default_nettype none

// Buffer write port, shared by all three buffers
interface buf_wr_if import cnn_pkg::*; #(
	parameter int BUF_ADDR_W = 8
);
	logic                  wr_en;
	logic [1:0]            target;  // Which buffer takes the word
	logic [BUF_ADDR_W-1:0] wr_addr;
	logic [DDR_DATA_W-1:0] wr_data;

	modport master (output wr_en, output target, output wr_addr, output wr_data);
	modport slave  (input wr_en, input target, input wr_addr, input wr_data);
endinterface

// One beat per buffer read, aligned with the read data
interface mac_op_if import cnn_pkg::*;;
	logic               valid;
	logic               first;  // Clear accumulator
	logic               last;   // Finish and emit
	logic [SHIFT_W-1:0] shift;

	modport master (output valid, output first, output last, output shift);
	modport slave  (input valid, input first, input last, input shift);
endinterface

`default_nettype wire

// File: cnn_pkg.sv
`default_nettype none

package cnn_pkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////
	localparam int INST_W     = 64;
	localparam int DDR_ADDR_W = 32; // Byte address
	localparam int DDR_DATA_W = 64; // Memory and buffer word
	localparam int LEN_W      = 16; // Word count
	localparam int ELEM_W     = 8;
	localparam int ELEMS      = 8;  // Elements per word
	localparam int RES_W      = 32;
	localparam int SHIFT_W    = 5;

	// Opcodes, top two bits of either view
	localparam logic [1:0] OP_LOAD = 2'b01;
	localparam logic [1:0] OP_COMP = 2'b10;

	// Buffer targets of a load
	localparam logic [1:0] TGT_BIAS   = 2'd1;
	localparam logic [1:0] TGT_WEIGHT = 2'd2;
	localparam logic [1:0] TGT_FEAT   = 2'd3;

	////////////////////////////////////////
	// Instruction word
	////////////////////////////////////////
	typedef struct packed {
		logic [1:0]            opcode;
		logic [1:0]            target;
		logic [3:0]            rsvd;
		logic [7:0]            buf_addr;  // First buffer word
		logic [LEN_W-1:0]      len;       // Words to fetch
		logic [DDR_ADDR_W-1:0] ddr_addr;
	} load_inst_s;

	typedef struct packed {
		logic [1:0]         opcode;
		logic [16:0]        rsvd;
		logic [SHIFT_W-1:0] shift;     // Arithmetic right shift of the sum
		logic [LEN_W-1:0]   len;       // Words in the dot product
		logic [7:0]         bias_addr;
		logic [7:0]         wgt_addr;
		logic [7:0]         feat_addr;
	} comp_inst_s;

	// Same 64 bits, view picked by the opcode
	typedef union packed {
		load_inst_s load;
		comp_inst_s comp;
	} inst_u;

endpackage

`default_nettype wire

// File: cnn_top.sv
`default_nettype none

module cnn_top import cnn_pkg::*; #(
	parameter int BUF_ADDR_W = 8
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  inst_u                 instruct,
	input  logic                  inst_empty,
	output logic                  inst_req,
	output logic [DDR_ADDR_W-1:0] ddr_st_addr,
	output logic [LEN_W-1:0]      ddr_len,
	output logic                  ddr_conf,
	input  logic                  ddr_fifo_empty,
	input  logic [DDR_DATA_W-1:0] ddr_fifo_data,
	output logic                  ddr_fifo_req,
	output logic                  result_valid,
	output logic [RES_W-1:0]      result_data,
	output logic                  idle
);

	logic                  fetch_start;
	logic [1:0]            fetch_target;
	logic [BUF_ADDR_W-1:0] fetch_buf_addr;
	logic [DDR_ADDR_W-1:0] fetch_ddr_addr;
	logic [LEN_W-1:0]      fetch_len;
	logic                  fetch_done;
	logic                  comp_start;
	comp_inst_s            comp_inst;
	logic [BUF_ADDR_W-1:0] feat_rd_addr;
	logic [BUF_ADDR_W-1:0] wgt_rd_addr;
	logic [BUF_ADDR_W-1:0] bias_rd_addr;
	logic [DDR_DATA_W-1:0] feat_word;
	logic [DDR_DATA_W-1:0] wgt_word;
	logic [DDR_DATA_W-1:0] bias_word;

	buf_wr_if #(.BUF_ADDR_W(BUF_ADDR_W)) buf_wr ();
	mac_op_if mac_op ();

	////////////////////////////////////////
	// Control and fetch
	////////////////////////////////////////
	inst_decoder #(.BUF_ADDR_W(BUF_ADDR_W)) decoder_i (
		.clk(clk), .rst_n(rst_n),
		.instruct(instruct), .inst_empty(inst_empty), .inst_req(inst_req),
		.fetch_start(fetch_start), .fetch_target(fetch_target),
		.fetch_buf_addr(fetch_buf_addr), .fetch_ddr_addr(fetch_ddr_addr),
		.fetch_len(fetch_len), .fetch_done(fetch_done),
		.comp_start(comp_start), .comp_inst(comp_inst),
		.result_valid(result_valid), .idle(idle)
	);

	ddr_fetch_control #(.BUF_ADDR_W(BUF_ADDR_W)) fetch_i (
		.clk(clk), .rst_n(rst_n),
		.start(fetch_start), .target(fetch_target), .buf_addr(fetch_buf_addr),
		.ddr_addr(fetch_ddr_addr), .len(fetch_len), .done(fetch_done),
		.ddr_st_addr(ddr_st_addr), .ddr_len(ddr_len), .ddr_conf(ddr_conf),
		.ddr_fifo_empty(ddr_fifo_empty), .ddr_fifo_data(ddr_fifo_data),
		.ddr_fifo_req(ddr_fifo_req), .wr(buf_wr.master)
	);

	// Buffers share one write port, split by target
	line_buffer #(.BUF_ADDR_W(BUF_ADDR_W), .BUF_ID(TGT_BIAS)) bias_buf (
		.clk(clk), .wr(buf_wr.slave), .rd_addr(bias_rd_addr), .rd_data(bias_word)
	);

	line_buffer #(.BUF_ADDR_W(BUF_ADDR_W), .BUF_ID(TGT_WEIGHT)) weight_buf (
		.clk(clk), .wr(buf_wr.slave), .rd_addr(wgt_rd_addr), .rd_data(wgt_word)
	);

	line_buffer #(.BUF_ADDR_W(BUF_ADDR_W), .BUF_ID(TGT_FEAT)) feat_buf (
		.clk(clk), .wr(buf_wr.slave), .rd_addr(feat_rd_addr), .rd_data(feat_word)
	);

	////////////////////////////////////////
	// Compute path
	////////////////////////////////////////
	compute_control #(.BUF_ADDR_W(BUF_ADDR_W)) comp_i (
		.clk(clk), .rst_n(rst_n), .start(comp_start), .inst(comp_inst),
		.feat_rd_addr(feat_rd_addr), .wgt_rd_addr(wgt_rd_addr),
		.bias_rd_addr(bias_rd_addr), .op(mac_op.master)
	);

	pe_core pe_i (
		.clk(clk), .rst_n(rst_n), .op(mac_op.slave),
		.feat_word(feat_word), .wgt_word(wgt_word), .bias_word(bias_word),
		.result_valid(result_valid), .result_data(result_data)
	);

endmodule

`default_nettype wire

// File: compute_control.sv
`default_nettype none

module compute_control import cnn_pkg::*; #(
	parameter int BUF_ADDR_W = 8
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start,
	input  comp_inst_s            inst,
	output logic [BUF_ADDR_W-1:0] feat_rd_addr,
	output logic [BUF_ADDR_W-1:0] wgt_rd_addr,
	output logic [BUF_ADDR_W-1:0] bias_rd_addr,
	mac_op_if.master              op
);

	logic             busy;       // A read beat this cycle
	logic             first_beat;
	logic [LEN_W-1:0] cnt;        // Beats left, this one included

	////////////////////////////////////////
	// Beat counter
	////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy       <= 1'b0;
			first_beat <= 1'b0;
			cnt        <= '0;
			op.valid   <= 1'b0;
			op.first   <= 1'b0;
			op.last    <= 1'b0;
		end else begin
			// Beat flags trail the address by one cycle
			op.valid <= busy;
			op.first <= busy && first_beat;
			op.last  <= busy && cnt == LEN_W'(1);
			if (start) begin
				busy       <= inst.len != '0;
				first_beat <= 1'b1;
				cnt        <= inst.len;
			end else if (busy) begin
				first_beat <= 1'b0;
				cnt        <= cnt - 1'b1;
				if (cnt == LEN_W'(1))
					busy <= 1'b0;
			end
		end
	end

	// Addresses walk, bias stays put
	always_ff @(posedge clk) begin
		if (start) begin
			feat_rd_addr <= BUF_ADDR_W'(inst.feat_addr);
			wgt_rd_addr  <= BUF_ADDR_W'(inst.wgt_addr);
			bias_rd_addr <= BUF_ADDR_W'(inst.bias_addr);
			op.shift     <= inst.shift;
		end else if (busy) begin
			feat_rd_addr <= feat_rd_addr + 1'b1;
			wgt_rd_addr  <= wgt_rd_addr + 1'b1;
		end
	end

	a_no_start_in_run: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> !busy);

endmodule

`default_nettype wire

// File: ddr_fetch_control.sv
`default_nettype none

module ddr_fetch_control import cnn_pkg::*; #(
	parameter int BUF_ADDR_W = 8
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start,
	input  logic [1:0]            target,
	input  logic [BUF_ADDR_W-1:0] buf_addr,
	input  logic [DDR_ADDR_W-1:0] ddr_addr,
	input  logic [LEN_W-1:0]      len,
	output logic                  done,
	output logic [DDR_ADDR_W-1:0] ddr_st_addr,
	output logic [LEN_W-1:0]      ddr_len,
	output logic                  ddr_conf,
	input  logic                  ddr_fifo_empty,
	input  logic [DDR_DATA_W-1:0] ddr_fifo_data,
	output logic                  ddr_fifo_req,
	buf_wr_if.master              wr
);

	logic                  busy;
	logic [LEN_W-1:0]      cnt;      // Pops still owed
	logic [BUF_ADDR_W-1:0] wr_addr_q;
	logic [1:0]            tgt_q;

	// No pop in the request cycle itself
	assign ddr_fifo_req = busy && !ddr_conf && !ddr_fifo_empty && (cnt != '0);

	// Popped word goes straight into the buffer
	assign wr.wr_en   = ddr_fifo_req;
	assign wr.target  = tgt_q;
	assign wr.wr_addr = wr_addr_q;
	assign wr.wr_data = ddr_fifo_data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			cnt      <= '0;
			ddr_conf <= 1'b0;
			done     <= 1'b0;
		end else begin
			ddr_conf <= start;
			done     <= (ddr_fifo_req && cnt == LEN_W'(1)) || (ddr_conf && cnt == '0);
			if (start) begin
				busy <= 1'b1;
				cnt  <= len;
			end else if (ddr_fifo_req) begin
				cnt <= cnt - 1'b1;
				if (cnt == LEN_W'(1))
					busy <= 1'b0;
			end else if (ddr_conf && cnt == '0) begin
				busy <= 1'b0; // Empty load
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			ddr_st_addr <= ddr_addr;
			ddr_len     <= len;
			wr_addr_q   <= buf_addr;
			tgt_q       <= target;
		end else if (ddr_fifo_req) begin
			wr_addr_q <= wr_addr_q + 1'b1;
		end
	end

	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
		ddr_fifo_req |-> !ddr_fifo_empty);

	// Quiet between a finished fetch and the next start
	a_no_pop_idle: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !ddr_fifo_req until start);

endmodule

`default_nettype wire

// File: inst_decoder.sv
`default_nettype none

module inst_decoder import cnn_pkg::*; #(
	parameter int BUF_ADDR_W = 8
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  inst_u                 instruct,
	input  logic                  inst_empty,
	output logic                  inst_req,
	output logic                  fetch_start,
	output logic [1:0]            fetch_target,
	output logic [BUF_ADDR_W-1:0] fetch_buf_addr,
	output logic [DDR_ADDR_W-1:0] fetch_ddr_addr,
	output logic [LEN_W-1:0]      fetch_len,
	input  logic                  fetch_done,
	output logic                  comp_start,
	output comp_inst_s            comp_inst,
	input  logic                  result_valid,
	output logic                  idle
);

	localparam logic [1:0] S_IDLE  = 2'd0;
	localparam logic [1:0] S_FETCH = 2'd1; // Waiting for fetch_done
	localparam logic [1:0] S_COMP  = 2'd2; // Waiting for the result

	logic [1:0] state;
	logic       is_load;
	logic       is_comp;

	assign is_load  = instruct.load.opcode == OP_LOAD;
	assign is_comp  = instruct.comp.opcode == OP_COMP;
	assign inst_req = (state == S_IDLE) && !inst_empty; // FWFT pop
	assign idle     = state == S_IDLE;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= S_IDLE;
			fetch_start <= 1'b0;
			comp_start  <= 1'b0;
		end else begin
			fetch_start <= inst_req && is_load;
			comp_start  <= inst_req && is_comp;
			case (state)
				S_IDLE: begin
					if (inst_req && is_load)
						state <= S_FETCH;
					else if (inst_req && is_comp)
						state <= S_COMP;
				end
				S_FETCH: if (fetch_done) state <= S_IDLE;
				S_COMP:  if (result_valid) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// Fields for the unit about to start
	always_ff @(posedge clk) begin
		if (inst_req && is_load) begin
			fetch_target   <= instruct.load.target;
			fetch_buf_addr <= BUF_ADDR_W'(instruct.load.buf_addr);
			fetch_ddr_addr <= instruct.load.ddr_addr;
			fetch_len      <= instruct.load.len;
		end
		if (inst_req && is_comp)
			comp_inst <= instruct.comp;
	end

	// One instruction in flight
	a_one_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
		inst_req && (is_load || is_comp) |=> !inst_req until_with (fetch_done || result_valid));

endmodule

`default_nettype wire

// File: line_buffer.sv
`default_nettype none

module line_buffer import cnn_pkg::*; #(
	parameter int         BUF_ADDR_W = 8,
	parameter logic [1:0] BUF_ID     = TGT_BIAS
) (
	input  logic                  clk,
	buf_wr_if.slave               wr,
	input  logic [BUF_ADDR_W-1:0] rd_addr,
	output logic [DDR_DATA_W-1:0] rd_data
);

	logic [DDR_DATA_W-1:0] mem [2**BUF_ADDR_W];

	always_ff @(posedge clk) begin
		if (wr.wr_en && wr.target == BUF_ID) // Only words aimed here
			mem[wr.wr_addr] <= wr.wr_data;
	end

	// Registered read, one cycle latency
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: pe_core.sv
`default_nettype none

module pe_core import cnn_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	mac_op_if.slave               op,
	input  logic [DDR_DATA_W-1:0] feat_word,
	input  logic [DDR_DATA_W-1:0] wgt_word,
	input  logic [DDR_DATA_W-1:0] bias_word,
	output logic                  result_valid,
	output logic [RES_W-1:0]      result_data
);

	localparam int PROD_W = 2 * ELEM_W;

	logic signed [PROD_W-1:0] prod [ELEMS];
	logic                     v1;
	logic                     first1;
	logic                     last1;
	logic [SHIFT_W-1:0]       shift1;
	logic signed [RES_W-1:0]  bias1;
	logic signed [RES_W-1:0]  tree_sum;
	logic signed [RES_W-1:0]  acc;
	logic                     v2;     // Finished sum waiting in acc
	logic [SHIFT_W-1:0]       shift2;
	logic signed [RES_W-1:0]  bias2;

	////////////////////////////////////////
	// Stage 1, multiply
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		for (int e = 0; e < ELEMS; e++)
			prod[e] <= $signed(feat_word[e*ELEM_W +: ELEM_W]) *
				$signed(wgt_word[e*ELEM_W +: ELEM_W]);
		first1 <= op.first;
		last1  <= op.last;
		shift1 <= op.shift;
		if (op.valid && op.last)
			bias1 <= $signed(bias_word[RES_W-1:0]); // Low half of the bias word
	end

	////////////////////////////////////////
	// Stage 2, add tree and accumulate
	////////////////////////////////////////
	always_comb begin
		tree_sum = '0;
		for (int e = 0; e < ELEMS; e++)
			tree_sum = tree_sum + RES_W'(prod[e]);
	end

	always_ff @(posedge clk) begin
		if (v1)
			acc <= first1 ? tree_sum : acc + tree_sum;
		if (v1 && last1) begin
			shift2 <= shift1;
			bias2  <= bias1;
		end
	end

	// Stage 3, bias and arithmetic shift
	always_ff @(posedge clk) begin
		if (v2)
			result_data <= (acc + bias2) >>> shift2;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			v1           <= 1'b0;
			v2           <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			v1           <= op.valid;
			v2           <= v1 && last1;
			result_valid <= v2;
		end
	end

	a_result_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid |=> !result_valid);

endmodule

`default_nettype wire

// File: tb_cnn_top.sv
`default_nettype none

module tb_cnn_top import cnn_pkg::*;;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int SEED         = 28684;
	localparam int CLK_NS       = 20;
	localparam int N_COMP       = 64;  // Random computes, every shift twice
	localparam int MAX_COMP_LEN = 16;
	localparam int MAX_LEN      = 64;  // Longest instruction, the fill loads

	logic                  clk;
	logic                  rst_n;
	inst_u                 instruct;
	logic                  inst_empty;
	logic                  inst_req;
	logic [DDR_ADDR_W-1:0] ddr_st_addr;
	logic [LEN_W-1:0]      ddr_len;
	logic                  ddr_conf;
	logic                  ddr_fifo_empty;
	logic [DDR_DATA_W-1:0] ddr_fifo_data;
	logic                  ddr_fifo_req;
	logic                  result_valid;
	logic [RES_W-1:0]      result_data;
	logic                  idle;

	inst_u                 prog [$];         // Instruction source
	logic [DDR_DATA_W-1:0] mem [bit [31:0]]; // Memory model, keyed by word index
	logic [DDR_DATA_W-1:0] fifo_q [$];       // Words owed to the DUT
	logic [DDR_DATA_W-1:0] mirror [4][256];  // Buffer copies, indexed by target
	logic [DDR_ADDR_W-1:0] conf_addr_q [$];
	logic [LEN_W-1:0]      conf_len_q [$];
	logic [RES_W-1:0]      exp_q [$];
	int                    errors;
	int                    checks;
	int                    results;
	int                    pops;
	int                    load_words;
	int                    n_comp;
	longint                watchdog_ns;
	bit                    running;
	bit                    prog_ready;

	cnn_top #(.BUF_ADDR_W(8)) dut_i (
		.clk(clk), .rst_n(rst_n),
		.instruct(instruct), .inst_empty(inst_empty), .inst_req(inst_req),
		.ddr_st_addr(ddr_st_addr), .ddr_len(ddr_len), .ddr_conf(ddr_conf),
		.ddr_fifo_empty(ddr_fifo_empty), .ddr_fifo_data(ddr_fifo_data),
		.ddr_fifo_req(ddr_fifo_req),
		.result_valid(result_valid), .result_data(result_data), .idle(idle)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////
	task automatic compare_value(string name, logic [63:0] exp, logic [63:0] act);
		checks++;
		if (act !== exp) begin
			$display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic report_error(string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		errors++;
	endtask

	////////////////////////////////////////
	// Program and reference model
	////////////////////////////////////////
	task automatic add_load(logic [1:0] tgt, logic [7:0] baddr, logic [LEN_W-1:0] len);
		inst_u       w;
		logic [31:0] daddr;
		daddr = $urandom & 32'h0fff_fff8; // Word aligned
		for (int i = 0; i < len; i++)
			if (!mem.exists((daddr >> 3) + i))
				mem[(daddr >> 3) + i] = {$urandom, $urandom};
		w = '0;
		w.load.opcode   = OP_LOAD;
		w.load.target   = tgt;
		w.load.buf_addr = baddr;
		w.load.len      = len;
		w.load.ddr_addr = daddr;
		prog.push_back(w);
		load_words += len;
	endtask

	task automatic add_comp(comp_inst_s c);
		inst_u w;
		w = '0;
		w.comp = c;
		prog.push_back(w);
		n_comp++;
	endtask

	// Bias low half, plus the dot product, then arithmetic shift
	function automatic logic [RES_W-1:0] predict(comp_inst_s c);
		int          sum;
		logic [63:0] f;
		logic [63:0] g;
		sum = int'($signed(mirror[TGT_BIAS][c.bias_addr][31:0]));
		for (int i = 0; i < c.len; i++) begin
			f = mirror[TGT_FEAT][8'(c.feat_addr + i)];
			g = mirror[TGT_WEIGHT][8'(c.wgt_addr + i)];
			for (int e = 0; e < ELEMS; e++)
				sum += $signed(f[e*8 +: 8]) * $signed(g[e*8 +: 8]);
		end
		return sum >>> c.shift;
	endfunction

	function automatic void apply_model(inst_u w);
		if (w.load.opcode == OP_LOAD) begin
			for (int i = 0; i < w.load.len; i++)
				mirror[w.load.target][8'(w.load.buf_addr + i)] = mem[(w.load.ddr_addr >> 3) + i];
			conf_addr_q.push_back(w.load.ddr_addr);
			conf_len_q.push_back(w.load.len);
		end else begin
			exp_q.push_back(predict(w.comp));
		end
	endfunction

	////////////////////////////////////////
	// Drive 2 ns after the edge
	////////////////////////////////////////
	always @(posedge clk) begin
		#2;
		if (running) begin
			if (prog.size() > 0 && $urandom_range(0, 3) != 0) begin
				instruct   = prog[0];
				inst_empty = 1'b0;
			end else begin
				inst_empty = 1'b1; // Source stall
			end
			if (fifo_q.size() > 0 && $urandom_range(0, 2) != 0) begin
				ddr_fifo_data  = fifo_q[0];
				ddr_fifo_empty = 1'b0;
			end else begin
				ddr_fifo_empty = 1'b1;
			end
		end
	end

	// Sample at the falling edge, outputs settled
	always @(negedge clk) begin
		inst_u w;
		if (running) begin
			if (inst_req) begin
				if (inst_empty)
					report_error("inst_req raised while inst_empty is high");
				if (prog.size() == 0) begin
					report_error("instruction popped from an empty source");
				end else begin
					w = prog.pop_front();
					apply_model(w);
				end
			end
			if (ddr_conf) begin
				if (conf_addr_q.size() == 0) begin
					report_error("ddr_conf without a pending load");
				end else begin
					compare_value("ddr_st_addr", conf_addr_q.pop_front(), ddr_st_addr);
					compare_value("ddr_len", conf_len_q.pop_front(), ddr_len);
				end
				if (fifo_q.size() != 0)
					report_error("previous fetch left words unread");
				for (int i = 0; i < ddr_len; i++)
					fifo_q.push_back(mem[(ddr_st_addr >> 3) + i]);
			end
			if (ddr_fifo_req) begin
				pops++;
				if (ddr_fifo_empty)
					report_error("ddr_fifo_req raised while ddr_fifo_empty is high");
				if (fifo_q.size() == 0)
					report_error("memory word popped beyond ddr_len");
				else
					void'(fifo_q.pop_front());
			end
			if (result_valid) begin
				results++;
				if (exp_q.size() == 0)
					report_error("result_valid without a pending compute");
				else
					compare_value("result_data", exp_q.pop_front(), result_data);
			end
		end
	end

	initial begin
		wait (prog_ready);
		#(watchdog_ns);
		$display("Timeout after %0d ns, %0d of %0d results, %0d errors",
			watchdog_ns, results, n_comp, errors);
		$display("test failed");
		$finish;
	end

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////
	initial begin
		comp_inst_s c;
		void'($urandom(SEED));
		rst_n          = 1'b0;
		instruct       = '0;
		inst_empty     = 1'b1;
		ddr_fifo_empty = 1'b1;
		ddr_fifo_data  = '0;
		for (int t = 1; t <= 3; t++) // Fill every buffer word first
			for (int b = 0; b < 256; b += MAX_LEN)
				add_load(2'(t), 8'(b), LEN_W'(MAX_LEN));
		for (int k = 0; k < N_COMP; k++) begin
			if ($urandom_range(0, 2) == 0)
				add_load(2'($urandom_range(1, 3)), 8'($urandom), LEN_W'($urandom_range(1, 8)));
			c           = '0;
			c.opcode    = OP_COMP;
			c.shift     = SHIFT_W'(k % 32);
			c.len       = LEN_W'($urandom_range(1, MAX_COMP_LEN));
			c.bias_addr = 8'($urandom);
			c.wgt_addr  = 8'($urandom);
			c.feat_addr = 8'($urandom);
			add_comp(c);
			if (k % 4 == 3) begin
				add_load(TGT_FEAT, c.feat_addr, LEN_W'(2)); // Overwrite, then repeat
				add_comp(c);
			end
		end
		watchdog_ns = longint'(prog.size()) * (MAX_LEN + 20) * 4 * CLK_NS;
		prog_ready  = 1'b1;

		repeat (3) @(posedge clk);
		#2 rst_n = 1'b1;
		@(negedge clk);
		compare_value("inst_req", 1'b0, inst_req);
		compare_value("ddr_conf", 1'b0, ddr_conf);
		compare_value("ddr_fifo_req", 1'b0, ddr_fifo_req);
		compare_value("result_valid", 1'b0, result_valid);
		compare_value("idle", 1'b1, idle);
		running = 1'b1;

		while (prog.size() != 0 || results < n_comp)
			@(negedge clk);
		repeat (5) @(negedge clk);
		compare_value("idle", 1'b1, idle);
		compare_value("pop count", load_words, pops);
		compare_value("result count", n_comp, results);
		if (fifo_q.size() != 0 || conf_addr_q.size() != 0 || exp_q.size() != 0)
			report_error("model queues not empty at the end of the run");

		$display("Checks %0d, errors %0d, results %0d of %0d, memory pops %0d",
			checks, errors, results, n_comp, pops);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire
